/* sprite_draw.f */
src/sprite_draw_pkg.sv
src/draw_request.sv
src/draw_player.sv
src/vga_write_port.sv
src/sprite_draw_top.sv
sim/sprite_draw_sva.sv
sim/tb_sprite_draw.sv

/* Bender.yml */
package:
  name: sprite_draw

sources:
  # RTL, compile order
  - files:
      - src/sprite_draw_pkg.sv
      - src/draw_request.sv
      - src/draw_player.sv
      - src/vga_write_port.sv
      - src/sprite_draw_top.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/sprite_draw_sva.sv
      - sim/tb_sprite_draw.sv

/* sim/tb_sprite_draw.sv */
`timescale 1ns/1ps

module tb_sprite_draw;

    localparam int CLOCK_PERIOD    = 10;
    localparam int RESET_CYCLES    = 5;
    localparam int NUM_PIXELS      = sprite_draw_pkg::SPRITE_SIZE * sprite_draw_pkg::SPRITE_SIZE;
    // Cycles after the start edge
    localparam int FIRST_WRITE     = 5;
    localparam int WRITE_SPACING   = 3;
    localparam int DRAW_CYCLES     = 15;
    localparam int RANDOM_DRAWS    = 200;
    localparam int NUM_DRAWS       = RANDOM_DRAWS + 10;
    localparam int CYCLES_PER_DRAW = 40;
    localparam int DRAIN_LIMIT     = 40;
    localparam int WATCHDOG_TIME   = (RESET_CYCLES + CYCLES_PER_DRAW * NUM_DRAWS) * CLOCK_PERIOD;

    typedef struct packed {
        logic [NUM_PIXELS-1:0]                          keep;
        sprite_draw_pkg::pixel_t [NUM_PIXELS-1:0]       pixel;
    } draw_exp_t;

    logic                                      clock;
    logic                                      reset;
    logic                                      start;
    sprite_draw_pkg::pos_x_t                   x;
    sprite_draw_pkg::pos_y_t                   y;
    logic [sprite_draw_pkg::PIXEL_X_WIDTH-1:0] vga_x;
    logic [sprite_draw_pkg::PIXEL_Y_WIDTH-1:0] vga_y;
    sprite_draw_pkg::colour_t                  vga_colour;
    logic                                      vga_write;
    logic                                      done;
    logic                                      busy;

    int cycle;
    int seed;
    int last_accept;

    // Pending expectations in absolute edges
    sprite_draw_pkg::pixel_t exp_pixel_q[$];
    int                      exp_cycle_q[$];
    int                      exp_start_q[$];
    int                      done_cycle_q[$];
    int                      done_start_q[$];
    int                      accept_q[$];

    sprite_draw_top i_dut (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .x          (x),
        .y          (y),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_write  (vga_write),
        .done       (done),
        .busy       (busy)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
    end

    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t: %s", $time, what);
        stop_on_error();
    endtask

    task automatic check_pixel(input string name, input sprite_draw_pkg::pixel_t expected,
                               input sprite_draw_pkg::pixel_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected (%0d,%0d) got (%0d,%0d)",
                     $time, name, expected.x, expected.y, actual.x, actual.y);
            stop_on_error();
        end
    endtask

    task automatic check_colour(input string name, input sprite_draw_pkg::colour_t expected,
                                input sprite_draw_pkg::colour_t actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_cycle(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %b got %b", $time, name, expected, actual);
            stop_on_error();
        end
    endtask

    // Pixel fields plus offsets in counter order with x in the low bit
    function automatic draw_exp_t expected_pixels(input sprite_draw_pkg::pos_x_t px,
                                                  input sprite_draw_pkg::pos_y_t py);
        draw_exp_t                                 result;
        logic [sprite_draw_pkg::PIXEL_X_WIDTH-1:0] col;
        logic [sprite_draw_pkg::PIXEL_Y_WIDTH-1:0] row;
        int                                        i;
        result = '0;
        for (i = 0; i < NUM_PIXELS; i++) begin
            // Truncation gives the wrap at coordinate width
            col = px.pixel + (i % sprite_draw_pkg::SPRITE_SIZE);
            row = py.pixel + (i / sprite_draw_pkg::SPRITE_SIZE);
            result.pixel[i].x = col;
            result.pixel[i].y = row;
            result.keep[i]    = (col < sprite_draw_pkg::SCREEN_WIDTH)
                             && (row < sprite_draw_pkg::SCREEN_HEIGHT);
        end
        return result;
    endfunction

    // busy is high from one edge after the start edge through edge 14
    function automatic logic expected_busy(input int now);
        int i;
        for (i = 0; i < accept_q.size(); i++) begin
            if (now >= accept_q[i] + 1 && now <= accept_q[i] + DRAW_CYCLES - 1) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic sprite_draw_pkg::pos_x_t make_pos_x(input int pixel, input int frac);
        sprite_draw_pkg::pos_x_t pos;
        pos.pixel = pixel;
        pos.frac  = frac;
        return pos;
    endfunction

    function automatic sprite_draw_pkg::pos_y_t make_pos_y(input int pixel, input int frac);
        sprite_draw_pkg::pos_y_t pos;
        pos.pixel = pixel;
        pos.frac  = frac;
        return pos;
    endfunction

    // One-cycle start pulse that the model ignores during a draw
    task automatic drive_start(input sprite_draw_pkg::pos_x_t px,
                               input sprite_draw_pkg::pos_y_t py,
                               output int start_edge, output bit accepted);
        draw_exp_t expect_list;
        int        i;
        @(negedge clock);
        start      = 1'b1;
        x          = px;
        y          = py;
        start_edge = cycle + 1;
        accepted   = (start_edge >= last_accept + DRAW_CYCLES);
        if (accepted) begin
            last_accept = start_edge;
            accept_q.push_back(start_edge);
            expect_list = expected_pixels(px, py);
            for (i = 0; i < NUM_PIXELS; i++) begin
                if (expect_list.keep[i]) begin
                    exp_pixel_q.push_back(expect_list.pixel[i]);
                    exp_cycle_q.push_back(start_edge + FIRST_WRITE + WRITE_SPACING * i);
                    exp_start_q.push_back(start_edge);
                end
            end
            done_cycle_q.push_back(start_edge + DRAW_CYCLES);
            done_start_q.push_back(start_edge);
        end
        @(negedge clock);
        start = 1'b0;
    endtask

    // Next start is sampled at edge target
    task automatic idle_until(input int target);
        while (cycle < target - 2) begin
            @(negedge clock);
        end
    endtask

    task automatic wait_for_draws();
        int waited;
        waited = 0;
        while (done_cycle_q.size() != 0) begin
            @(negedge clock);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                report_problem("done never arrived for a started draw");
            end
        end
        @(negedge clock);
    endtask

    always @(negedge clock) begin : compare
        sprite_draw_pkg::pixel_t want_pixel;
        int                      want_cycle;
        int                      from_edge;
        if (i_dut.i_sprite_draw_sva.fail_count != 0) begin
            report_problem("an assertion bound to the DUT failed");
        end
        if (!reset) begin
            check_flag("busy", expected_busy(cycle), busy);
            if (vga_write) begin
                if (exp_pixel_q.size() == 0) begin
                    report_problem("vga_write pulsed with no pixel left to draw");
                end else begin
                    want_pixel = exp_pixel_q.pop_front();
                    want_cycle = exp_cycle_q.pop_front();
                    from_edge  = exp_start_q.pop_front();
                    check_cycle("vga_write cycle", want_cycle - from_edge, cycle - from_edge);
                    check_pixel("vga_x/vga_y", want_pixel, {vga_x, vga_y});
                    check_colour("vga_colour", sprite_draw_pkg::PLAYER_COLOUR, vga_colour);
                end
            end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle) begin
                report_problem($sformatf("write of pixel (%0d,%0d) never appeared",
                                         exp_pixel_q[0].x, exp_pixel_q[0].y));
            end
            if (done) begin
                if (done_cycle_q.size() == 0) begin
                    report_problem("done pulsed with no draw in progress");
                end else begin
                    want_cycle = done_cycle_q.pop_front();
                    from_edge  = done_start_q.pop_front();
                    check_cycle("done cycle", want_cycle - from_edge, cycle - from_edge);
                end
            end else if (done_cycle_q.size() != 0 && done_cycle_q[0] <= cycle) begin
                report_problem("done did not pulse at the end of a draw");
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        report_problem($sformatf("watchdog expired after %0d cycles", cycle));
    end

    initial begin
        int          start_edge;
        int          first_edge;
        bit          accepted;
        int          random_done;
        int          gap;
        logic [31:0] r;
        cycle       = 0;
        seed        = 32'hf0036bac;
        last_accept = -1000;
        reset       = 1'b1;
        start       = 1'b0;
        x           = '0;
        y           = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Idle outputs after reset
        @(negedge clock);
        check_flag("vga_write", 1'b0, vga_write);
        check_flag("done", 1'b0, done);
        check_flag("busy", 1'b0, busy);
        check_pixel("vga_x/vga_y", '0, {vga_x, vga_y});
        check_colour("vga_colour", '0, vga_colour);

        // Plain draw at (10,20)
        drive_start(make_pos_x(10, 0), make_pos_y(20, 0), start_edge, accepted);
        wait_for_draws();

        // Fraction bits are dropped
        drive_start(make_pos_x(10, 6'h25), make_pos_y(20, 6'h3f), start_edge, accepted);
        wait_for_draws();

        // Clipping at the right and bottom edges and after wrap
        drive_start(make_pos_x(159, 0), make_pos_y(60, 0), start_edge, accepted);
        wait_for_draws();
        drive_start(make_pos_x(30, 0), make_pos_y(119, 0), start_edge, accepted);
        wait_for_draws();
        drive_start(make_pos_x(255, 6'h3f), make_pos_y(127, 6'h3f), start_edge, accepted);
        wait_for_draws();

        // Starts during a draw are ignored
        // A start on the done edge is taken
        drive_start(make_pos_x(40, 0), make_pos_y(40, 0), first_edge, accepted);
        idle_until(first_edge + 2);
        drive_start(make_pos_x(80, 0), make_pos_y(80, 0), start_edge, accepted);
        idle_until(first_edge + 13);
        drive_start(make_pos_x(100, 0), make_pos_y(100, 0), start_edge, accepted);
        idle_until(first_edge + DRAW_CYCLES);
        drive_start(make_pos_x(90, 3), make_pos_y(90, 5), start_edge, accepted);
        wait_for_draws();

        // Random positions with random gaps so some starts land mid-draw
        random_done = 0;
        while (random_done < RANDOM_DRAWS) begin
            r = $random(seed);
            x = r[sprite_draw_pkg::POS_X_WIDTH-1:0];
            r = $random(seed);
            y = r[sprite_draw_pkg::POS_Y_WIDTH-1:0];
            drive_start(x, y, start_edge, accepted);
            if (accepted) begin
                random_done++;
            end
            gap = {$random(seed)} % 18;
            repeat (gap) @(negedge clock);
        end
        wait_for_draws();

        if (exp_pixel_q.size() == 0 && done_cycle_q.size() == 0
                && i_dut.i_sprite_draw_sva.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_problem("expected writes, done pulses or assertions failed at the end of the run");
        end
    end

endmodule

/* sim/sprite_draw_sva.sv */
`timescale 1ns/1ps

module sprite_draw_sva (
    input logic clock,
    input logic reset,
    input logic vga_write,
    input logic done,
    input logic busy
);

    // Number of failed assertions
    int fail_count = 0;

    // The sweep never writes on adjacent cycles
    property write_single_cycle;
        @(posedge clock) disable iff (reset)
        vga_write |=> !vga_write;
    endproperty

    property done_single_cycle;
        @(posedge clock) disable iff (reset)
        done |=> !done;
    endproperty

    // busy drops on the same edge that raises done
    property busy_falls_with_done;
        @(posedge clock) disable iff (reset)
        $fell(busy) |-> done;
    endproperty

    property done_while_idle;
        @(posedge clock) disable iff (reset)
        done |-> !busy;
    endproperty

    property write_only_when_busy;
        @(posedge clock) disable iff (reset)
        vga_write |-> busy;
    endproperty

    // Synchronous reset clears the outputs one edge later
    property outputs_low_in_reset;
        @(posedge clock)
        reset |=> (!vga_write && !done && !busy);
    endproperty

    a_write_single_cycle: assert property (write_single_cycle) else begin
        fail_count++;
        $error("vga_write high on two consecutive cycles");
    end
    a_done_single_cycle: assert property (done_single_cycle) else begin
        fail_count++;
        $error("done high on two consecutive cycles");
    end
    a_busy_falls_with_done: assert property (busy_falls_with_done) else begin
        fail_count++;
        $error("busy fell without done");
    end
    a_done_while_idle: assert property (done_while_idle) else begin
        fail_count++;
        $error("busy still high while done pulses");
    end
    a_write_only_when_busy: assert property (write_only_when_busy) else begin
        fail_count++;
        $error("vga_write while busy is low");
    end
    a_outputs_low_in_reset: assert property (outputs_low_in_reset) else begin
        fail_count++;
        $error("outputs not low during reset");
    end

endmodule

bind sprite_draw_top sprite_draw_sva i_sprite_draw_sva (
    .clock     (clock),
    .reset     (reset),
    .vga_write (vga_write),
    .done      (done),
    .busy      (busy)
);

/* src/sprite_draw_top.sv */
`timescale 1ns/1ps

module sprite_draw_top (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      start,
    input  sprite_draw_pkg::pos_x_t                   x,
    input  sprite_draw_pkg::pos_y_t                   y,
    output logic [sprite_draw_pkg::PIXEL_X_WIDTH-1:0] vga_x,
    output logic [sprite_draw_pkg::PIXEL_Y_WIDTH-1:0] vga_y,
    output sprite_draw_pkg::colour_t                  vga_colour,
    output logic                                      vga_write,
    output logic                                      done,
    output logic                                      busy
);

    logic                       req_valid;
    sprite_draw_pkg::draw_req_t req;
    logic                       pixel_write;
    sprite_draw_pkg::pixel_t    pixel;
    logic                       sweep_done;

    draw_request i_draw_request (
        .clock      (clock),
        .reset      (reset),
        .start      (start),
        .x          (x),
        .y          (y),
        .sweep_done (sweep_done),
        .req_valid  (req_valid),
        .req        (req),
        .busy       (busy)
    );

    draw_player i_draw_player (
        .clock       (clock),
        .reset       (reset),
        .req_valid   (req_valid),
        .req         (req),
        .pixel_write (pixel_write),
        .pixel       (pixel),
        .sweep_done  (sweep_done)
    );

    vga_write_port i_vga_write_port (
        .clock       (clock),
        .reset       (reset),
        .pixel_write (pixel_write),
        .pixel       (pixel),
        .sweep_done  (sweep_done),
        .vga_x       (vga_x),
        .vga_y       (vga_y),
        .vga_colour  (vga_colour),
        .vga_write   (vga_write),
        .done        (done)
    );

endmodule

/* src/vga_write_port.sv */
`timescale 1ns/1ps

module vga_write_port (
    input  logic                                      clock,
    input  logic                                      reset,
    input  logic                                      pixel_write,
    input  sprite_draw_pkg::pixel_t                   pixel,
    input  logic                                      sweep_done,
    output logic [sprite_draw_pkg::PIXEL_X_WIDTH-1:0] vga_x,
    output logic [sprite_draw_pkg::PIXEL_Y_WIDTH-1:0] vga_y,
    output sprite_draw_pkg::colour_t                  vga_colour,
    output logic                                      vga_write,
    output logic                                      done
);

    logic on_screen;

    // Anything past the right or bottom edge is dropped
    assign on_screen = pixel_write
                    && (pixel.x < sprite_draw_pkg::SCREEN_WIDTH)
                    && (pixel.y < sprite_draw_pkg::SCREEN_HEIGHT);

    always_ff @(posedge clock) begin
        if (reset) begin
            vga_write  <= 1'b0;
            done       <= 1'b0;
            vga_x      <= '0;
            vga_y      <= '0;
            vga_colour <= '0;
        end else begin
            vga_write <= on_screen;
            done      <= sweep_done;
            // Coordinates hold their last written value between writes
            if (on_screen) begin
                vga_x      <= pixel.x;
                vga_y      <= pixel.y;
                vga_colour <= sprite_draw_pkg::PLAYER_COLOUR;
            end
        end
    end

endmodule

/* src/draw_player.sv */
`timescale 1ns/1ps

module draw_player (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       req_valid,
    input  sprite_draw_pkg::draw_req_t req,
    output logic                       pixel_write,
    output sprite_draw_pkg::pixel_t    pixel,
    output logic                       sweep_done
);

    typedef enum logic [2:0] {
        WAIT        = 3'd0,
        INITIALIZE  = 3'd1,
        ADD_OFFSET  = 3'd2,
        WRITE_PIXEL = 3'd3,
        INCREMENT   = 3'd4,
        DONE        = 3'd5
    } state_t;

    state_t state;

    // Control lines from FSM to datapath
    logic load;
    logic clear_counter;
    logic add_offset;
    logic increment_counter;
    logic counter_at_max;

    // Datapath registers
    sprite_draw_pkg::draw_req_t              corner;
    logic [2*sprite_draw_pkg::OFFSET_WIDTH-1:0] counter;
    logic [sprite_draw_pkg::OFFSET_WIDTH-1:0]   x_offset;
    logic [sprite_draw_pkg::OFFSET_WIDTH-1:0]   y_offset;

    // Transition table
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= WAIT;
        end else begin
            case (state)
                WAIT: begin
                    if (req_valid) begin
                        state <= INITIALIZE;
                    end
                end
                INITIALIZE: begin
                    state <= ADD_OFFSET;
                end
                ADD_OFFSET: begin
                    state <= WRITE_PIXEL;
                end
                WRITE_PIXEL: begin
                    state <= counter_at_max ? DONE : INCREMENT;
                end
                INCREMENT: begin
                    state <= ADD_OFFSET;
                end
                DONE: begin
                    state <= WAIT;
                end
                default: begin
                    state <= WAIT;
                end
            endcase
        end
    end

    // Controls decoded straight from the state
    assign load              = (state == INITIALIZE);
    assign clear_counter     = (state == INITIALIZE);
    assign add_offset        = (state == ADD_OFFSET);
    assign increment_counter = (state == INCREMENT);
    assign pixel_write       = (state == WRITE_PIXEL);
    assign sweep_done        = (state == DONE);

    // Low half steps along x, high half along y
    assign x_offset       = counter[sprite_draw_pkg::OFFSET_WIDTH-1:0];
    assign y_offset       = counter[2*sprite_draw_pkg::OFFSET_WIDTH-1:
                                    sprite_draw_pkg::OFFSET_WIDTH];
    assign counter_at_max = &counter;

    always_ff @(posedge clock) begin
        if (reset || clear_counter) begin
            counter <= '0;
        end else if (increment_counter) begin
            counter <= counter + 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (load) begin
            corner <= req;
        end
    end

    // Sum wraps at coordinate width, the output stage clips it
    always_ff @(posedge clock) begin
        if (add_offset) begin
            pixel.x <= corner.x_base + sprite_draw_pkg::PIXEL_X_WIDTH'(x_offset);
            pixel.y <= corner.y_base + sprite_draw_pkg::PIXEL_Y_WIDTH'(y_offset);
        end
    end

endmodule

/* src/draw_request.sv */
`timescale 1ns/1ps

module draw_request (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       start,
    input  sprite_draw_pkg::pos_x_t    x,
    input  sprite_draw_pkg::pos_y_t    y,
    input  logic                       sweep_done,
    output logic                       req_valid,
    output sprite_draw_pkg::draw_req_t req,
    output logic                       busy
);

    // High for the one cycle between sampling start and issuing the request
    logic pending;
    logic accept;

    // A sweep that finishes this cycle frees the drawer for the next start
    assign accept = start && !pending && (!busy || sweep_done);

    // Control state
    always_ff @(posedge clock) begin
        if (reset) begin
            pending   <= 1'b0;
            req_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            pending   <= accept;
            req_valid <= pending;
            if (pending) begin
                busy <= 1'b1;
            end else if (sweep_done) begin
                busy <= 1'b0;
            end
        end
    end

    // Corner in whole pixels, fraction bits are dropped
    always_ff @(posedge clock) begin
        if (accept) begin
            req.x_base <= x.pixel;
            req.y_base <= y.pixel;
        end
    end

endmodule

/* src/sprite_draw_pkg.sv */
package sprite_draw_pkg;

    // Visible screen area of the VGA adapter
    localparam int SCREEN_WIDTH  = 160;
    localparam int SCREEN_HEIGHT = 120;

    // Square sprite, side length in pixels
    localparam int SPRITE_SIZE  = 2;
    localparam int OFFSET_WIDTH = $clog2(SPRITE_SIZE);

    // Fixed-point player position, pixel part above the fraction
    localparam int FRAC_BITS     = 6;
    localparam int POS_X_WIDTH   = 14;
    localparam int POS_Y_WIDTH   = 13;
    localparam int PIXEL_X_WIDTH = POS_X_WIDTH - FRAC_BITS;
    localparam int PIXEL_Y_WIDTH = POS_Y_WIDTH - FRAC_BITS;

    // 6 bits per channel, red green blue
    localparam int CHANNEL_BITS = 6;

    typedef logic [3*CHANNEL_BITS-1:0] colour_t;

    localparam logic [CHANNEL_BITS-1:0] CHANNEL_MID = 1 << (CHANNEL_BITS - 1);
    localparam colour_t PLAYER_COLOUR = {CHANNEL_MID, CHANNEL_MID, CHANNEL_MID};

    typedef struct packed {
        logic [PIXEL_X_WIDTH-1:0] pixel;
        logic [FRAC_BITS-1:0]     frac;
    } pos_x_t;

    typedef struct packed {
        logic [PIXEL_Y_WIDTH-1:0] pixel;
        logic [FRAC_BITS-1:0]     frac;
    } pos_y_t;

    // One screen coordinate
    typedef struct packed {
        logic [PIXEL_X_WIDTH-1:0] x;
        logic [PIXEL_Y_WIDTH-1:0] y;
    } pixel_t;

    // Top-left corner of the sprite in whole pixels
    typedef struct packed {
        logic [PIXEL_X_WIDTH-1:0] x_base;
        logic [PIXEL_Y_WIDTH-1:0] y_base;
    } draw_req_t;

endpackage
